//--- verilog/hisPkg.sv
`default_nettype none

// data formats shared by the histogram datapath
package hisPkg;

    // timestamp width, one raw time-of-flight sample
    parameter int DATA_W = 10;

    // bin index width, 32 bins per histogram
    parameter int BIN_W = 5;

    // per-bin hit counter width
    // counters stop at all ones
    parameter int CNT_W = 8;

    // binning grid of one builder
    // FINE is offset by half a bin against COARSE
    typedef enum logic {
        COARSE,
        FINE
    } binKindT;

endpackage

`default_nettype wire

//--- verilog/hisCtrlPkg.sv
`default_nettype none

// control encodings of the peak finder FSMs
package hisCtrlPkg;

    // histogram builder phases
    typedef enum logic [1:0] {
        ACCUM,
        SCAN,
        REPORT
    } builderStateT;

    // frame sequencing in the resolver
    typedef enum logic [1:0] {
        ACQUIRE,
        WAIT_PEAKS,
        OUTPUT
    } resolverStateT;

endpackage

`default_nettype wire

//--- verilog/peakIf.sv
`timescale 1ns/10ps
`default_nettype none

// one builder's peak report toward the resolver
// valid/ready, report held until taken
interface peakIf #(
    parameter int BIN_W = hisPkg::BIN_W,
    parameter int CNT_W = hisPkg::CNT_W
);
    logic [BIN_W-1:0] bin;
    logic [CNT_W-1:0] count;
    logic             valid;
    logic             ready;

    // histogram side
    modport builder (output bin, output count, output valid, input ready);

    // combining side
    modport resolver (input bin, input count, input valid, output ready);

endinterface

`default_nettype wire

//--- verilog/hisBuilder.sv
`timescale 1ns/10ps
`default_nettype none

// one histogram over a frame of timestamps
// accumulate, then argmax scan with clear, then report
module hisBuilder #(
    parameter hisPkg::binKindT kind = hisPkg::COARSE,
    parameter int DATA_W = hisPkg::DATA_W,
    parameter int BIN_W = hisPkg::BIN_W,
    parameter int CNT_W = hisPkg::CNT_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] sampleData,
    input  logic              sampleEn,
    input  logic              frameEnd,
    peakIf.builder            peak
);

    localparam int SHIFT = DATA_W - BIN_W;
    localparam int NUM_BINS = 2 ** BIN_W;
    // half a bin in timestamp units
    localparam logic [DATA_W-1:0] HALF_BIN = DATA_W'(1) << (SHIFT - 1);

    hisCtrlPkg::builderStateT state;

    // bin counters, flip-flop array
    logic [CNT_W-1:0] binMem [NUM_BINS];

    logic [DATA_W-1:0] shiftedData;
    logic [BIN_W-1:0]  binIdx;
    logic [BIN_W-1:0]  scanIdx;
    logic [CNT_W-1:0]  scanCnt;
    logic [CNT_W-1:0]  maxCnt;
    logic [BIN_W-1:0]  maxBin;
    // scan started by reset, only clears
    logic              clearScan;

    // fine grid: move samples up by half a bin
    // the add wraps at the top of the timestamp range
    assign shiftedData = (kind == hisPkg::FINE) ? sampleData + HALF_BIN : sampleData;

    // top bits select the bin
    assign binIdx = shiftedData[DATA_W-1 -: BIN_W];

    // counter under the scan pointer
    assign scanCnt = binMem[scanIdx];

    // counters: increment while accumulating, zero behind the scan
    always_ff @(posedge clk) begin
        if (state == hisCtrlPkg::SCAN) begin
            binMem[scanIdx] <= '0;
        end else if (state == hisCtrlPkg::ACCUM && sampleEn) begin
            // saturate at all ones
            if (binMem[binIdx] != '1) begin
                binMem[binIdx] <= binMem[binIdx] + 1'b1;
            end
        end
    end

    // phase control and running maximum
    always_ff @(posedge clk) begin
        if (rst) begin
            // clear every bin before the first frame
            state     <= hisCtrlPkg::SCAN;
            scanIdx   <= '0;
            clearScan <= 1'b1;
            maxCnt    <= '0;
            maxBin    <= '0;
        end else begin
            case (state)
                hisCtrlPkg::ACCUM: begin
                    // last sample counted this edge, scan starts next cycle
                    if (frameEnd) begin
                        state     <= hisCtrlPkg::SCAN;
                        scanIdx   <= '0;
                        clearScan <= 1'b0;
                        maxCnt    <= '0;
                        maxBin    <= '0;
                    end
                end
                hisCtrlPkg::SCAN: begin
                    // strictly larger only, ties keep the lower index
                    if (scanCnt > maxCnt) begin
                        maxCnt <= scanCnt;
                        maxBin <= scanIdx;
                    end
                    scanIdx <= scanIdx + 1'b1;
                    // one bin per cycle, done after the last one
                    if (scanIdx == BIN_W'(NUM_BINS - 1)) begin
                        state <= clearScan ? hisCtrlPkg::ACCUM : hisCtrlPkg::REPORT;
                    end
                end
                hisCtrlPkg::REPORT: begin
                    // hold until the resolver takes it
                    if (peak.ready) begin
                        state <= hisCtrlPkg::ACCUM;
                    end
                end
                default: begin
                    state <= hisCtrlPkg::ACCUM;
                end
            endcase
        end
    end

    // report straight from the max registers
    assign peak.bin   = maxBin;
    assign peak.count = maxCnt;
    assign peak.valid = (state == hisCtrlPkg::REPORT);

endmodule

`default_nettype wire

//--- verilog/peakResolver.sv
`timescale 1ns/10ps
`default_nettype none

// frame sequencing and coarse/fine peak combining
module peakResolver #(
    parameter int DATA_W = hisPkg::DATA_W,
    parameter int BIN_W = hisPkg::BIN_W,
    parameter int CNT_W = hisPkg::CNT_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              sampleLast,
    input  logic              sampleValid,
    output logic              sampleReady,
    output logic              sampleEn,
    output logic              frameEnd,
    peakIf.resolver           coarse,
    peakIf.resolver           fine,
    output logic [DATA_W-1:0] peakPos,
    output logic [CNT_W-1:0]  peakCount,
    output logic              peakSource,
    output logic              peakValid,
    input  logic              peakReady
);

    localparam int SHIFT = DATA_W - BIN_W;
    localparam int NUM_BINS = 2 ** BIN_W;
    localparam logic [DATA_W-1:0] HALF_BIN = DATA_W'(1) << (SHIFT - 1);

    hisCtrlPkg::resolverStateT state;

    // post-reset clear scan tracking
    logic [BIN_W-1:0] clearCnt;
    logic             clearing;

    logic              takePeaks;
    logic              coarseWins;
    logic [DATA_W-1:0] coarsePos;
    logic [DATA_W-1:0] finePos;

    // input handshake, only while acquiring
    assign sampleReady = (state == hisCtrlPkg::ACQUIRE) && !clearing;
    assign sampleEn    = sampleValid && sampleReady;
    assign frameEnd    = sampleEn && sampleLast;

    // take both reports in the same cycle
    assign takePeaks  = (state == hisCtrlPkg::WAIT_PEAKS) && coarse.valid && fine.valid;
    assign coarse.ready = takePeaks;
    assign fine.ready   = takePeaks;

    // coarse bin center
    assign coarsePos = {coarse.bin, {SHIFT{1'b0}}} + HALF_BIN;

    // fine bin center sits on a coarse edge
    // fine bin 0 lands on position 0 by the wrap
    assign finePos = {fine.bin, {SHIFT{1'b0}}};

    // equal counts go to coarse
    assign coarseWins = (coarse.count >= fine.count);

    // matches the builders' own reset scan length
    always_ff @(posedge clk) begin
        if (rst) begin
            clearCnt <= '0;
            clearing <= 1'b1;
        end else if (clearing) begin
            clearCnt <= clearCnt + 1'b1;
            if (clearCnt == BIN_W'(NUM_BINS - 1)) begin
                clearing <= 1'b0;
            end
        end
    end

    // frame FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= hisCtrlPkg::ACQUIRE;
            peakValid <= 1'b0;
        end else begin
            case (state)
                hisCtrlPkg::ACQUIRE: begin
                    if (frameEnd) begin
                        state <= hisCtrlPkg::WAIT_PEAKS;
                    end
                end
                hisCtrlPkg::WAIT_PEAKS: begin
                    if (takePeaks) begin
                        state <= hisCtrlPkg::OUTPUT;
                    end
                end
                hisCtrlPkg::OUTPUT: begin
                    // result registered at take, valid one cycle later
                    if (!peakValid) begin
                        peakValid <= 1'b1;
                    end else if (peakReady) begin
                        peakValid <= 1'b0;
                        state     <= hisCtrlPkg::ACQUIRE;
                    end
                end
                default: begin
                    state     <= hisCtrlPkg::ACQUIRE;
                    peakValid <= 1'b0;
                end
            endcase
        end
    end

    // result registers, loaded once per frame
    // stay put while peakValid waits for peakReady
    always_ff @(posedge clk) begin
        if (takePeaks) begin
            if (coarseWins) begin
                peakPos    <= coarsePos;
                peakCount  <= coarse.count;
                peakSource <= 1'b0;
            end else begin
                peakPos    <= finePos;
                peakCount  <= fine.count;
                peakSource <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/peakFinderTop.sv
`timescale 1ns/10ps
`default_nettype none

// time-of-flight peak finder
// coarse and half-bin-shifted histograms, combined into one peak
module peakFinderTop #(
    parameter int DATA_W = hisPkg::DATA_W,
    parameter int BIN_W = hisPkg::BIN_W,
    parameter int CNT_W = hisPkg::CNT_W
) (
    input  logic              clk,
    input  logic              rst,
    // sample stream
    input  logic [DATA_W-1:0] sampleData,
    input  logic              sampleLast,
    input  logic              sampleValid,
    output logic              sampleReady,
    // peak result
    output logic [DATA_W-1:0] peakPos,
    output logic [CNT_W-1:0]  peakCount,
    output logic              peakSource,
    output logic              peakValid,
    input  logic              peakReady
);

    // broadcast from resolver to both builders
    logic sampleEn;
    logic frameEnd;

    // per-builder reports
    peakIf #(.BIN_W(BIN_W), .CNT_W(CNT_W)) coarsePeak ();
    peakIf #(.BIN_W(BIN_W), .CNT_W(CNT_W)) finePeak ();

    // bins on the top timestamp bits
    hisBuilder #(
        .kind   (hisPkg::COARSE),
        .DATA_W (DATA_W),
        .BIN_W  (BIN_W),
        .CNT_W  (CNT_W)
    ) coarseBuilder (
        .clk        (clk),
        .rst        (rst),
        .sampleData (sampleData),
        .sampleEn   (sampleEn),
        .frameEnd   (frameEnd),
        .peak       (coarsePeak.builder)
    );

    // same stream, half a bin later
    hisBuilder #(
        .kind   (hisPkg::FINE),
        .DATA_W (DATA_W),
        .BIN_W  (BIN_W),
        .CNT_W  (CNT_W)
    ) fineBuilder (
        .clk        (clk),
        .rst        (rst),
        .sampleData (sampleData),
        .sampleEn   (sampleEn),
        .frameEnd   (frameEnd),
        .peak       (finePeak.builder)
    );

    peakResolver #(
        .DATA_W (DATA_W),
        .BIN_W  (BIN_W),
        .CNT_W  (CNT_W)
    ) resolver (
        .clk         (clk),
        .rst         (rst),
        .sampleLast  (sampleLast),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .sampleEn    (sampleEn),
        .frameEnd    (frameEnd),
        .coarse      (coarsePeak.resolver),
        .fine        (finePeak.resolver),
        .peakPos     (peakPos),
        .peakCount   (peakCount),
        .peakSource  (peakSource),
        .peakValid   (peakValid),
        .peakReady   (peakReady)
    );

endmodule

`default_nettype wire

//--- sim/peakFinderMon.sv
`timescale 1ns/10ps
`default_nettype none

// result checker on the DUT output port
// expected entries are consumed in frame order
module peakFinderMon #(
    parameter int DATA_W = hisPkg::DATA_W,
    parameter int CNT_W = hisPkg::CNT_W
) (
    input logic              clk,
    input logic              rst,
    input logic [DATA_W-1:0] peakPos,
    input logic [CNT_W-1:0]  peakCount,
    input logic              peakSource,
    input logic              peakValid,
    input logic              peakReady
);

    logic [DATA_W-1:0] expPos [$];
    logic [CNT_W-1:0]  expCount [$];
    logic              expSource [$];

    int resultCount = 0;
    int passCount = 0;
    int failCount = 0;
    bit ok;

    task automatic addExpected(input logic [DATA_W-1:0] pos, input logic [CNT_W-1:0] cnt,
                               input logic src);
        expPos.push_back(pos);
        expCount.push_back(cnt);
        expSource.push_back(src);
    endtask

    // one field, error line on mismatch
    function automatic bit fieldOk(string name, logic [31:0] expVal, logic [31:0] actVal);
        if (expVal !== actVal) begin
            $display("CHECK FAILED at %0t: %s expected %0h actual %0h",
                     $time, name, expVal, actVal);
        end
        return expVal === actVal;
    endfunction

    // a result transfers on valid and ready
    always @(posedge clk) begin
        if (!rst && peakValid === 1'b1 && peakReady === 1'b1) begin
            resultCount++;
            if (expPos.size() == 0) begin
                failCount++;
                $display("frame %0d: result arrived with no expected entry left", resultCount);
            end else begin
                // & so that every field gets reported
                ok = fieldOk("peakPos", expPos.pop_front(), peakPos)
                   & fieldOk("peakCount", expCount.pop_front(), peakCount)
                   & fieldOk("peakSource", expSource.pop_front(), peakSource);
                if (ok) begin
                    passCount++;
                end else begin
                    failCount++;
                end
                $display("frame %0d %s: pos %h count %0d source %0d", resultCount,
                         ok ? "passed" : "failed", peakPos, peakCount, peakSource);
            end
        end
    end

    task automatic printSummary();
        $display("frames passed %0d, failed %0d, never seen %0d",
                 passCount, failCount, expPos.size());
    endtask

endmodule

`default_nettype wire

//--- sim/peakFinder_chk.sv
`timescale 1ns/10ps
`default_nettype none

// resolver handshake and reset properties
module peakFinder_chk #(
    parameter int DATA_W = hisPkg::DATA_W,
    parameter int CNT_W = hisPkg::CNT_W
) (
    input logic                      clk,
    input logic                      rst,
    input hisCtrlPkg::resolverStateT state,
    input logic                      sampleReady,
    input logic                      peakValid,
    input logic                      peakReady,
    input logic [DATA_W-1:0]         peakPos,
    input logic [CNT_W-1:0]          peakCount,
    input logic                      peakSource
);

    // number of assertion failures so far
    int failCount = 0;

    // result frozen while the sink stalls
    holdResult: assert property (@(posedge clk) disable iff (rst)
        peakValid && !peakReady |=> peakValid && $stable(peakPos)
            && $stable(peakCount) && $stable(peakSource))
    else begin
        failCount++;
        $error("result changed while peakReady was low");
    end

    // no samples taken while waiting or outputting
    readyInAcquire: assert property (@(posedge clk) disable iff (rst)
        state != hisCtrlPkg::ACQUIRE |-> !sampleReady)
    else begin
        failCount++;
        $error("sampleReady high outside ACQUIRE");
    end

    resetClearsValid: assert property (@(posedge clk) rst |=> !peakValid)
    else begin
        failCount++;
        $error("peakValid high in the cycle after reset");
    end

endmodule

bind peakResolver peakFinder_chk #(.DATA_W(DATA_W), .CNT_W(CNT_W)) chk (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .sampleReady (sampleReady),
    .peakValid   (peakValid),
    .peakReady   (peakReady),
    .peakPos     (peakPos),
    .peakCount   (peakCount),
    .peakSource  (peakSource)
);

`default_nettype wire

//--- sim/peakFinderTb.sv
`timescale 1ns/10ps
`default_nettype none

// peak finder testbench top
// frames from sim/peak_tests.txt, results compared in peakFinderMon
module peakFinderTb;

    localparam int DATA_W = hisPkg::DATA_W;
    localparam int BIN_W = hisPkg::BIN_W;
    localparam int CNT_W = hisPkg::CNT_W;
    localparam int NUM_BINS = 2 ** BIN_W;

    logic              clk;
    logic              rst;
    logic [DATA_W-1:0] sampleData;
    logic              sampleLast;
    logic              sampleValid;
    logic              sampleReady;
    logic [DATA_W-1:0] peakPos;
    logic [CNT_W-1:0]  peakCount;
    logic              peakSource;
    logic              peakValid;
    logic              peakReady;

    // expanded sample stream, one entry per transfer
    logic [DATA_W-1:0] stimData [$];
    logic              stimLast [$];
    int                numFrames;
    int                totalSamples;
    bit                loadOk;
    bit                timedOut;

    peakFinderTop #(.DATA_W(DATA_W), .BIN_W(BIN_W), .CNT_W(CNT_W)) DUT (
        .clk         (clk),
        .rst         (rst),
        .sampleData  (sampleData),
        .sampleLast  (sampleLast),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady),
        .peakPos     (peakPos),
        .peakCount   (peakCount),
        .peakSource  (peakSource),
        .peakValid   (peakValid),
        .peakReady   (peakReady)
    );

    peakFinderMon #(.DATA_W(DATA_W), .CNT_W(CNT_W)) mon (
        .clk        (clk),
        .rst        (rst),
        .peakPos    (peakPos),
        .peakCount  (peakCount),
        .peakSource (peakSource),
        .peakValid  (peakValid),
        .peakReady  (peakReady)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // s lines expand into samples, e lines go to the monitor
    task automatic loadTests(output bit ok);
        int                fd;
        int                rc;
        string             line;
        logic [DATA_W-1:0] val;
        int                num;
        int                flag;
        ok = 1'b0;
        fd = $fopen("sim/peak_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (line.len() > 0 && line.getc(0) == "s") begin
                    rc = $sscanf(line, "s %h %d %d", val, num, flag);
                    for (int i = 0; i < num; i++) begin
                        stimData.push_back(val);
                        // last flag only on the final repeat
                        stimLast.push_back(flag != 0 && i == num - 1);
                    end
                    totalSamples += num;
                end else if (line.len() > 0 && line.getc(0) == "e") begin
                    rc = $sscanf(line, "e %h %d %d", val, num, flag);
                    mon.addExpected(val, CNT_W'(num), flag[0]);
                    numFrames++;
                end
            end
            $fclose(fd);
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic sendSample(input logic [DATA_W-1:0] ts, input logic last);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            sampleData  = ts;
            sampleLast  = last;
            // random gaps in the stream
            sampleValid = ($urandom % 5) != 0;
            // sampleReady has settled since the last edge
            taken = sampleValid && sampleReady;
            @(posedge clk);
            #1;
        end
        sampleValid = 1'b0;
    endtask

    initial begin
        int limit;
        clk          = 1'b0;
        rst          = 1'b1;
        sampleData   = '0;
        sampleLast   = 1'b0;
        sampleValid  = 1'b0;
        peakReady    = 1'b0;
        numFrames    = 0;
        totalSamples = 0;
        timedOut     = 1'b0;
        void'($urandom(32'h2b8cbc0a));
        loadTests(loadOk);
        limit = (totalSamples + numFrames * (NUM_BINS + 10)) * 8;
        if (loadOk) begin
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
            // builders clear their bins after reset
            repeat (NUM_BINS + 1) @(posedge clk);
            #1;
            fork
                begin
                    foreach (stimData[i]) begin
                        sendSample(stimData[i], stimLast[i]);
                    end
                    wait (mon.resultCount >= numFrames);
                    repeat (4) @(posedge clk);
                end
                begin
                    // result side back-pressure, about one cycle in three
                    forever begin
                        @(posedge clk);
                        #1;
                        peakReady = ($urandom % 3) != 0;
                    end
                end
                begin
                    // watchdog
                    repeat (limit) @(posedge clk);
                    timedOut = 1'b1;
                end
            join_any
        end else begin
            $display("could not open sim/peak_tests.txt, no stimulus to run");
        end
        mon.printSummary();
        if (loadOk && !timedOut && numFrames > 0 && mon.failCount == 0
                && mon.resultCount == numFrames && DUT.resolver.chk.failCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            if (timedOut) begin
                $display("watchdog expired after %0d cycles, results still missing", limit);
            end
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/peak_tests.txt
# s <timestamp hex> <repeat count> <last flag on the final repeat>
# e <expected peakPos hex> <expected peakCount> <expected peakSource>
s 064 3 0
s 078 2 1
e 070 5 0
s 07e 3 0
s 082 3 1
e 080 6 1
s 040 2 0
s 1a0 2 1
e 050 2 0
s 0fe 2 0
s 102 2 0
s 07e 2 0
s 082 2 1
e 080 4 1
s 3fc 3 0
s 002 3 1
e 000 6 1
s 200 300 1
e 210 255 0
s 205 1 0
s 3e0 2 1
e 3f0 2 0

//--- build.f
verilog/hisPkg.sv
verilog/hisCtrlPkg.sv
verilog/peakIf.sv
verilog/hisBuilder.sv
verilog/peakResolver.sv
verilog/peakFinderTop.sv
sim/peakFinderMon.sv
sim/peakFinder_chk.sv
sim/peakFinderTb.sv

//--- Bender.yml
package:
  name: peak_finder
  description: "Time-of-flight histogram peak finder"

sources:
  - verilog/hisPkg.sv
  - verilog/hisCtrlPkg.sv
  - verilog/peakIf.sv
  - verilog/hisBuilder.sv
  - verilog/peakResolver.sv
  - verilog/peakFinderTop.sv
  - target: simulation
    files:
      - sim/peakFinderMon.sv
      - sim/peakFinder_chk.sv
      - sim/peakFinderTb.sv
